/* rtl/decode_pkg.sv */
package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [7:0] exc_t;

  // primary opcode, instr[31:27]
  typedef enum logic [4:0] {
    op_alu_reg   = 5'd0,
    op_alu_imm   = 5'd1,
    op_lui       = 5'd2,
    op_mem_abs_w = 5'd3,  op_mem_rel_w = 5'd4,  op_mem_imm_w = 5'd5,
    op_mem_abs_h = 5'd6,  op_mem_rel_h = 5'd7,  op_mem_imm_h = 5'd8,
    op_mem_abs_b = 5'd9,  op_mem_rel_b = 5'd10, op_mem_imm_b = 5'd11,
    op_br_imm    = 5'd12,
    op_br_abs    = 5'd13,
    op_br_rel    = 5'd14,
    op_syscall   = 5'd15,
    op_fadd_abs  = 5'd16, op_fadd_rel  = 5'd17, op_fadd_imm  = 5'd18,
    op_swap_abs  = 5'd19, op_swap_rel  = 5'd20, op_swap_imm  = 5'd21,
    op_adpc      = 5'd22,
    op_rsvd_23   = 5'd23, op_rsvd_24   = 5'd24, op_rsvd_25   = 5'd25,
    op_rsvd_26   = 5'd26, op_rsvd_27   = 5'd27, op_rsvd_28   = 5'd28,
    op_rsvd_29   = 5'd29, op_rsvd_30   = 5'd30,
    op_priv      = 5'd31
  } opcode_e;

  // position of a micro-op inside an atomic sequence
  typedef enum logic [1:0] {
    step_load  = 2'd0,
    step_add   = 2'd1,
    step_store = 2'd2
  } crack_step_e;

  localparam exc_t exc_none        = 8'h00;
  localparam exc_t exc_invalid     = 8'h80;
  localparam exc_t exc_priv        = 8'h81;
  localparam exc_t syscall_ok_code = 8'd1;

  localparam logic [4:0] alu_add         = 5'd14;
  localparam logic [4:0] alu_imm_max     = 5'd18;
  localparam logic [4:0] alu_reg_max     = 5'd22;
  localparam logic [4:0] branch_code_max = 5'd18;
  localparam logic [4:0] priv_type_max   = 5'd3;

endpackage

/* rtl/instr_classifier.sv */
module instr_classifier (
  input  decode_pkg::word_t   instr,
  input  logic                instr_valid,
  input  logic                kmode,
  input  logic                crack_active,
  output decode_pkg::opcode_e opcode,
  output logic [4:0]          alu_op,
  output logic                is_load,
  output logic                is_store,
  output logic                is_branch,
  output logic                is_abs_mem,
  output logic                is_priv,
  output decode_pkg::exc_t    exc
);

  logic known;
  logic is_rsvd;
  logic is_mem;
  logic is_syscall;
  logic load_bit;
  logic bad;
  decode_pkg::word_t instr_dec;

  // unknown words (x in simulation) decode as an all-zero word
  always_comb begin
    known = 1'b1;
    is_rsvd = 1'b0;
    case (instr[31:27]) inside
      [5'd0:5'd22], 5'd31: known = 1'b1;
      [5'd23:5'd30]: is_rsvd = 1'b1;
      default: known = 1'b0;
    endcase
  end

  assign instr_dec = known ? instr : '0;
  assign opcode = decode_pkg::opcode_e'(instr_dec[31:27]);

  // alu op sits lower in the register form
  assign alu_op = (opcode == decode_pkg::op_alu_reg) ? instr_dec[9:5] : instr_dec[16:12];

  assign is_mem = opcode inside {[decode_pkg::op_mem_abs_w:decode_pkg::op_mem_imm_b]};
  assign is_branch = opcode inside {[decode_pkg::op_br_imm:decode_pkg::op_br_rel]};
  assign is_syscall = (opcode == decode_pkg::op_syscall);
  assign is_priv = (opcode == decode_pkg::op_priv);
  assign is_abs_mem = opcode inside {decode_pkg::op_mem_abs_w, decode_pkg::op_mem_abs_h,
                                     decode_pkg::op_mem_abs_b};

  // immediate memory forms keep the load bit above their 21-bit offset
  assign load_bit = (opcode inside {decode_pkg::op_mem_imm_w, decode_pkg::op_mem_imm_h,
                                    decode_pkg::op_mem_imm_b}) ? instr_dec[21] : instr_dec[16];
  assign is_load = is_mem && load_bit;
  assign is_store = is_mem && !load_bit;

  assign bad = is_rsvd ||
    ((opcode == decode_pkg::op_alu_imm) && (alu_op > decode_pkg::alu_imm_max)) ||
    ((opcode == decode_pkg::op_alu_reg) && (alu_op > decode_pkg::alu_reg_max)) ||
    (is_branch && (instr_dec[26:22] > decode_pkg::branch_code_max)) ||
    (is_syscall && (instr_dec[7:0] != decode_pkg::syscall_ok_code)) ||
    (is_priv && (instr_dec[16:12] > decode_pkg::priv_type_max));

  always_comb begin
    if (!(instr_valid || crack_active)) begin
      exc = decode_pkg::exc_none;
    end else if (bad) begin
      exc = decode_pkg::exc_invalid;
    end else if (is_priv && !kmode) begin
      exc = decode_pkg::exc_priv;
    end else if (is_syscall) begin
      exc = instr_dec[7:0];
    end else begin
      exc = decode_pkg::exc_none;
    end
  end

endmodule

/* rtl/imm_gen.sv */
module imm_gen (
  input  decode_pkg::word_t       instr,
  input  decode_pkg::opcode_e     opcode,
  input  logic [4:0]              alu_op,
  input  logic                    crack_active,
  input  decode_pkg::crack_step_e step,
  output decode_pkg::word_t       imm
);

  decode_pkg::word_t se12;
  decode_pkg::word_t base_imm;
  decode_pkg::word_t crack_imm;
  logic [4:0] alu_shift;

  assign se12 = {{20{instr[11]}}, instr[11:0]};
  // byte rotate in steps of 8
  assign alu_shift = {instr[9:8], 3'b000};

  always_comb begin
    base_imm = '0;
    case (opcode)
      decode_pkg::op_alu_imm: begin
        if (alu_op <= 5'd6) begin
          base_imm = {24'b0, instr[7:0]} << alu_shift;
        end else if (alu_op <= 5'd13) begin
          base_imm = {27'b0, instr[4:0]};
        end else begin
          base_imm = se12;
        end
      end
      decode_pkg::op_lui: base_imm = {instr[21:0], 10'b0};
      decode_pkg::op_br_imm, decode_pkg::op_adpc: base_imm = {{10{instr[21]}}, instr[21:0]};
      decode_pkg::op_mem_abs_w, decode_pkg::op_mem_abs_h, decode_pkg::op_mem_abs_b:
        base_imm = se12 << instr[13:12];
      decode_pkg::op_mem_rel_w, decode_pkg::op_mem_rel_h, decode_pkg::op_mem_rel_b:
        base_imm = {{16{instr[15]}}, instr[15:0]};
      decode_pkg::op_mem_imm_w, decode_pkg::op_mem_imm_h, decode_pkg::op_mem_imm_b:
        base_imm = {{11{instr[20]}}, instr[20:0]};
      default: base_imm = '0;
    endcase
  end

  // atomics carry a 17-bit offset in the imm variant, 12-bit otherwise
  always_comb begin
    if (step == decode_pkg::step_add) begin
      crack_imm = '0;
    end else if (opcode inside {decode_pkg::op_fadd_imm, decode_pkg::op_swap_imm}) begin
      crack_imm = {{15{instr[16]}}, instr[16:0]};
    end else begin
      crack_imm = se12;
    end
  end

  assign imm = crack_active ? crack_imm : base_imm;

endmodule

/* rtl/reg_select.sv */
module reg_select (
  input  decode_pkg::word_t       instr,
  input  decode_pkg::opcode_e     opcode,
  input  logic [4:0]              alu_op,
  input  logic                    is_store,
  input  logic                    is_priv,
  input  logic                    is_abs_mem,
  input  logic                    is_load,
  input  logic                    fetch_add,
  input  logic                    crack_active,
  input  decode_pkg::crack_step_e step,
  output decode_pkg::reg_idx_t    s_1,
  output decode_pkg::reg_idx_t    s_2,
  output decode_pkg::reg_idx_t    tgt_1,
  output decode_pkg::reg_idx_t    tgt_2,
  output logic                    is_post_inc
);

  decode_pkg::reg_idx_t r_a;
  decode_pkg::reg_idx_t r_b;
  decode_pkg::reg_idx_t base;
  decode_pkg::reg_idx_t data;
  decode_pkg::reg_idx_t base_s_1;
  decode_pkg::reg_idx_t base_s_2;
  decode_pkg::reg_idx_t crack_s_1;
  decode_pkg::reg_idx_t crack_s_2;
  logic is_reg_branch;
  logic no_rb_read;
  logic alias_postinc;
  logic store_slot;
  logic [1:0] inc_type;

  // register branches keep r_a and r_b in the low bits
  assign is_reg_branch = opcode inside {decode_pkg::op_br_abs, decode_pkg::op_br_rel};
  assign r_a = is_reg_branch ? instr[9:5] : instr[26:22];
  assign r_b = is_reg_branch ? instr[4:0] : instr[21:17];

  // 0 offset, 1 pre-increment, 2 post-increment
  assign inc_type = instr[15:14];

  // alu op 6 is a move and ignores r_b
  assign no_rb_read = (opcode inside {decode_pkg::op_lui, decode_pkg::op_mem_imm_w,
                                      decode_pkg::op_mem_imm_h, decode_pkg::op_mem_imm_b,
                                      decode_pkg::op_br_imm, decode_pkg::op_syscall}) ||
    ((opcode inside {decode_pkg::op_alu_reg, decode_pkg::op_alu_imm}) && (alu_op == 5'd6));

  assign base_s_1 = no_rb_read ? '0 : r_b;
  // stores and privileged ops read r_a, only alu-reg reads r_c
  assign base_s_2 = (is_store || is_priv) ? r_a :
                    ((opcode == decode_pkg::op_alu_reg) ? instr[4:0] : '0);

  // atomics: base in [16:12] (none for imm variant), data in [21:17]
  assign base = (opcode inside {decode_pkg::op_fadd_imm, decode_pkg::op_swap_imm}) ?
                '0 : instr[16:12];
  assign data = instr[21:17];

  assign crack_s_1 = (fetch_add && (step == decode_pkg::step_add)) ? data : base;
  assign crack_s_2 = (!fetch_add || (step == decode_pkg::step_load)) ? data : r_a;

  assign s_1 = crack_active ? crack_s_1 : base_s_1;
  assign s_2 = crack_active ? crack_s_2 : base_s_2;

  // post-increment load into its own base would write r_a twice
  assign alias_postinc = is_abs_mem && (inc_type == 2'd2) && is_load && (r_a == r_b);
  assign store_slot = crack_active ? (step == decode_pkg::step_store) : is_store;

  assign tgt_1 = (store_slot || alias_postinc) ? '0 : r_a;
  assign tgt_2 = (is_abs_mem && (inc_type != 2'd0)) ? r_b : '0;
  assign is_post_inc = is_abs_mem && (inc_type == 2'd2);

endmodule

/* rtl/atomic_cracker.sv */
module atomic_cracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  decode_pkg::word_t       instr,
  input  logic                    instr_valid,
  input  logic                    stall,
  input  logic                    flush,
  output decode_pkg::word_t       cur_instr,
  output logic                    crack_active,
  output logic                    fetch_add,
  output decode_pkg::crack_step_e step,
  output decode_pkg::opcode_e     uop_opcode,
  output logic                    decode_stall
);

  typedef enum logic {
    st_idle,
    st_busy
  } state_e;

  state_e state;
  decode_pkg::crack_step_e step_q;
  logic fa_q;
  decode_pkg::word_t instr_q;
  decode_pkg::opcode_e live_op;
  logic live_fadd;
  logic live_swap;
  logic start;
  logic busy;

  assign live_op = decode_pkg::opcode_e'(instr[31:27]);
  assign live_fadd = live_op inside {decode_pkg::op_fadd_abs, decode_pkg::op_fadd_rel,
                                     decode_pkg::op_fadd_imm};
  assign live_swap = live_op inside {decode_pkg::op_swap_abs, decode_pkg::op_swap_rel,
                                     decode_pkg::op_swap_imm};

  assign busy = (state == st_busy);
  // the load micro-op issues straight from the live word
  assign start = !busy && instr_valid && !stall && !flush && (live_fadd || live_swap);

  assign crack_active = busy || start;
  assign decode_stall = busy || start;
  assign fetch_add = busy ? fa_q : live_fadd;
  assign step = busy ? step_q : decode_pkg::step_load;
  assign cur_instr = busy ? instr_q : instr;

  always_comb begin
    case (decode_pkg::opcode_e'(cur_instr[31:27]))
      decode_pkg::op_fadd_abs, decode_pkg::op_swap_abs: uop_opcode = decode_pkg::op_mem_abs_w;
      decode_pkg::op_fadd_rel, decode_pkg::op_swap_rel: uop_opcode = decode_pkg::op_mem_rel_w;
      default: uop_opcode = decode_pkg::op_mem_imm_w;
    endcase
    if (fetch_add && (step == decode_pkg::step_add)) begin
      uop_opcode = decode_pkg::op_alu_reg;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      step_q <= decode_pkg::step_load;
      fa_q <= 1'b0;
    end else if (!stall) begin
      if (flush) begin
        state <= st_idle;
        step_q <= decode_pkg::step_load;
      end else if (start) begin
        state <= st_busy;
        fa_q <= live_fadd;
        // swap skips the add step
        step_q <= live_fadd ? decode_pkg::step_add : decode_pkg::step_store;
      end else if (busy) begin
        if (step_q == decode_pkg::step_store) begin
          state <= st_idle;
          step_q <= decode_pkg::step_load;
        end else begin
          step_q <= decode_pkg::step_store;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      instr_q <= instr;
    end
  end

endmodule

/* rtl/decode_stage.sv */
module decode_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  decode_pkg::word_t    instr,
  input  decode_pkg::word_t    pc,
  input  logic                 instr_valid,
  input  logic                 kmode,
  input  logic                 stall,
  input  logic                 flush,
  output decode_pkg::opcode_e  opcode_out,
  output logic [4:0]           alu_op_out,
  output decode_pkg::reg_idx_t s_1_out,
  output decode_pkg::reg_idx_t s_2_out,
  output decode_pkg::reg_idx_t tgt_1_out,
  output decode_pkg::reg_idx_t tgt_2_out,
  output decode_pkg::word_t    imm_out,
  output logic [4:0]           branch_code_out,
  output decode_pkg::exc_t     exc_out,
  output logic                 bubble_out,
  output decode_pkg::word_t    pc_out,
  output logic                 is_load_out,
  output logic                 is_store_out,
  output logic                 is_branch_out,
  output logic                 is_post_inc_out,
  output logic                 is_atomic_out,
  output logic [1:0]           atomic_step_out,
  output logic                 decode_stall
);

  decode_pkg::word_t cur_instr;
  logic crack_active;
  logic fetch_add;
  decode_pkg::crack_step_e step;
  decode_pkg::opcode_e uop_opcode;
  decode_pkg::opcode_e opcode;
  logic [4:0] alu_op;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_abs_mem;
  logic is_priv;
  decode_pkg::exc_t exc;
  decode_pkg::word_t imm;
  decode_pkg::reg_idx_t s_1;
  decode_pkg::reg_idx_t s_2;
  decode_pkg::reg_idx_t tgt_1;
  decode_pkg::reg_idx_t tgt_2;
  logic is_post_inc;
  logic kill;
  logic live_exc;
  logic slot_kill;
  logic add_step;
  decode_pkg::opcode_e dec_opcode;
  logic [4:0] dec_alu_op;
  logic dec_load;
  logic dec_store;

  atomic_cracker u_cracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .stall        (stall),
    .flush        (flush),
    .cur_instr    (cur_instr),
    .crack_active (crack_active),
    .fetch_add    (fetch_add),
    .step         (step),
    .uop_opcode   (uop_opcode),
    .decode_stall (decode_stall)
  );

  instr_classifier u_classifier (
    .instr        (cur_instr),
    .instr_valid  (instr_valid),
    .kmode        (kmode),
    .crack_active (crack_active),
    .opcode       (opcode),
    .alu_op       (alu_op),
    .is_load      (is_load),
    .is_store     (is_store),
    .is_branch    (is_branch),
    .is_abs_mem   (is_abs_mem),
    .is_priv      (is_priv),
    .exc          (exc)
  );

  imm_gen u_imm_gen (
    .instr        (cur_instr),
    .opcode       (opcode),
    .alu_op       (alu_op),
    .crack_active (crack_active),
    .step         (step),
    .imm          (imm)
  );

  reg_select u_reg_select (
    .instr        (cur_instr),
    .opcode       (opcode),
    .alu_op       (alu_op),
    .is_store     (is_store),
    .is_priv      (is_priv),
    .is_abs_mem   (is_abs_mem),
    .is_load      (is_load),
    .fetch_add    (fetch_add),
    .crack_active (crack_active),
    .step         (step),
    .s_1          (s_1),
    .s_2          (s_2),
    .tgt_1        (tgt_1),
    .tgt_2        (tgt_2),
    .is_post_inc  (is_post_inc)
  );

  assign add_step = crack_active && fetch_add && (step == decode_pkg::step_add);
  assign dec_opcode = crack_active ? uop_opcode : opcode;
  assign dec_alu_op = add_step ? decode_pkg::alu_add : alu_op;
  assign dec_load = crack_active ? (step == decode_pkg::step_load) : is_load;
  assign dec_store = crack_active ? (step == decode_pkg::step_store) : is_store;

  // a faulting slot stays live but carries no control
  assign kill = flush || !(instr_valid || crack_active);
  assign live_exc = !kill && (exc != decode_pkg::exc_none);
  assign slot_kill = kill || live_exc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opcode_out <= decode_pkg::op_alu_reg;
      alu_op_out <= '0;
      s_1_out <= '0;
      s_2_out <= '0;
      tgt_1_out <= '0;
      tgt_2_out <= '0;
      imm_out <= '0;
      branch_code_out <= '0;
      exc_out <= decode_pkg::exc_none;
      bubble_out <= 1'b1;
      pc_out <= '0;
      is_load_out <= 1'b0;
      is_store_out <= 1'b0;
      is_branch_out <= 1'b0;
      is_post_inc_out <= 1'b0;
      is_atomic_out <= 1'b0;
      atomic_step_out <= '0;
    end else if (!stall) begin
      opcode_out <= slot_kill ? decode_pkg::op_alu_reg : dec_opcode;
      alu_op_out <= slot_kill ? '0 : dec_alu_op;
      s_1_out <= slot_kill ? '0 : s_1;
      s_2_out <= slot_kill ? '0 : s_2;
      tgt_1_out <= slot_kill ? '0 : tgt_1;
      tgt_2_out <= slot_kill ? '0 : tgt_2;
      imm_out <= slot_kill ? '0 : imm;
      branch_code_out <= slot_kill ? '0 : cur_instr[26:22];
      exc_out <= kill ? decode_pkg::exc_none : exc;
      bubble_out <= kill;
      pc_out <= pc;
      is_load_out <= !slot_kill && dec_load;
      is_store_out <= !slot_kill && dec_store;
      is_branch_out <= !slot_kill && is_branch;
      is_post_inc_out <= !slot_kill && is_post_inc;
      is_atomic_out <= !slot_kill && crack_active;
      atomic_step_out <= slot_kill ? 2'd0 : step;
    end
  end

endmodule

/* tb/tb_decode.sv */
module tb_decode;

  localparam int max_vec = 64;
  localparam int period = 20;

  logic clk;
  logic rst_n;
  decode_pkg::word_t instr;
  decode_pkg::word_t pc;
  logic instr_valid;
  logic kmode;
  logic stall;
  logic flush;

  decode_pkg::opcode_e opcode_out;
  logic [4:0] alu_op_out;
  decode_pkg::reg_idx_t s_1_out;
  decode_pkg::reg_idx_t s_2_out;
  decode_pkg::reg_idx_t tgt_1_out;
  decode_pkg::reg_idx_t tgt_2_out;
  decode_pkg::word_t imm_out;
  logic [4:0] branch_code_out;
  decode_pkg::exc_t exc_out;
  logic bubble_out;
  decode_pkg::word_t pc_out;
  logic is_load_out;
  logic is_store_out;
  logic is_branch_out;
  logic is_post_inc_out;
  logic is_atomic_out;
  logic [1:0] atomic_step_out;
  logic decode_stall;

  // one entry per golden line
  string names [max_vec];
  logic [31:0] v_stall [max_vec];
  logic [31:0] v_flush [max_vec];
  logic [31:0] v_valid [max_vec];
  logic [31:0] v_kmode [max_vec];
  logic [31:0] v_instr [max_vec];
  logic [31:0] v_pc [max_vec];
  logic [31:0] e_bubble [max_vec];
  logic [31:0] e_opcode [max_vec];
  logic [31:0] e_s1 [max_vec];
  logic [31:0] e_s2 [max_vec];
  logic [31:0] e_tgt1 [max_vec];
  logic [31:0] e_imm [max_vec];
  logic [31:0] e_exc [max_vec];
  logic [31:0] e_load [max_vec];
  logic [31:0] e_store [max_vec];
  logic [31:0] e_step [max_vec];
  logic [31:0] e_dstall [max_vec];
  // pc and micro-op flag as held by the output register
  logic [31:0] x_pc [max_vec];
  logic x_atomic [max_vec];
  int num_vec;
  logic loaded;

  decode_stage UUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr           (instr),
    .pc              (pc),
    .instr_valid     (instr_valid),
    .kmode           (kmode),
    .stall           (stall),
    .flush           (flush),
    .opcode_out      (opcode_out),
    .alu_op_out      (alu_op_out),
    .s_1_out         (s_1_out),
    .s_2_out         (s_2_out),
    .tgt_1_out       (tgt_1_out),
    .tgt_2_out       (tgt_2_out),
    .imm_out         (imm_out),
    .branch_code_out (branch_code_out),
    .exc_out         (exc_out),
    .bubble_out      (bubble_out),
    .pc_out          (pc_out),
    .is_load_out     (is_load_out),
    .is_store_out    (is_store_out),
    .is_branch_out   (is_branch_out),
    .is_post_inc_out (is_post_inc_out),
    .is_atomic_out   (is_atomic_out),
    .atomic_step_out (atomic_step_out),
    .decode_stall    (decode_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch test %s field %s expected %h actual %h", test, field, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic read_golden();
    int fd;
    int cnt;
    string line;
    fd = $fopen("tb/golden_decode.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open golden file tb/golden_decode.txt");
    end
    num_vec = 0;
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      // skip blank lines and the column comment
      if (line.len() > 1 && line.getc(0) != "#") begin
        if (num_vec >= max_vec) begin
          stop_with_error("golden file has more lines than the testbench can hold");
        end
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      names[num_vec], v_stall[num_vec], v_flush[num_vec], v_valid[num_vec],
                      v_kmode[num_vec], v_instr[num_vec], v_pc[num_vec], e_bubble[num_vec],
                      e_opcode[num_vec], e_s1[num_vec], e_s2[num_vec], e_tgt1[num_vec],
                      e_imm[num_vec], e_exc[num_vec], e_load[num_vec], e_store[num_vec],
                      e_step[num_vec], e_dstall[num_vec]);
        if (cnt != 18) begin
          stop_with_error({"golden file line is malformed: ", line});
        end
        num_vec = num_vec + 1;
      end
    end
    $fclose(fd);
    if (num_vec == 0) begin
      stop_with_error("golden file holds no vectors");
    end
  endtask

  // a stalled line keeps whatever the previous line left in the register
  task automatic derive_held_outputs();
    logic [31:0] pc_q;
    logic atomic_q;
    pc_q = '0;
    atomic_q = 1'b0;
    for (int k = 0; k < num_vec; k++) begin
      if (!v_stall[k][0]) begin
        pc_q = v_pc[k];
        // a micro-op is a live slot issued while decode_stall is high
        atomic_q = e_dstall[k][0] && !e_bubble[k][0];
      end
      x_pc[k] = pc_q;
      x_atomic[k] = atomic_q;
    end
  endtask

  task automatic drive_vector(input int k);
    stall = v_stall[k][0];
    flush = v_flush[k][0];
    instr_valid = v_valid[k][0];
    kmode = v_kmode[k][0];
    pc = v_pc[k];
    // empty slots carry a random word that must not leak through
    instr = v_valid[k][0] ? v_instr[k] : $urandom();
  endtask

  task automatic drive_idle();
    stall = 1'b0;
    flush = 1'b0;
    instr_valid = 1'b0;
    kmode = 1'b0;
    instr = $urandom();
  endtask

  // registered outputs that belong to golden line k
  task automatic check_registered(input int k);
    check_field(names[k], "bubble_out", e_bubble[k], 32'(bubble_out));
    check_field(names[k], "opcode_out", e_opcode[k], 32'(opcode_out));
    check_field(names[k], "s_1_out", e_s1[k], 32'(s_1_out));
    check_field(names[k], "s_2_out", e_s2[k], 32'(s_2_out));
    check_field(names[k], "tgt_1_out", e_tgt1[k], 32'(tgt_1_out));
    check_field(names[k], "imm_out", e_imm[k], imm_out);
    check_field(names[k], "exc_out", e_exc[k], 32'(exc_out));
    check_field(names[k], "is_load_out", e_load[k], 32'(is_load_out));
    check_field(names[k], "is_store_out", e_store[k], 32'(is_store_out));
    check_field(names[k], "atomic_step_out", e_step[k], 32'(atomic_step_out));
    check_field(names[k], "is_atomic_out", 32'(x_atomic[k]), 32'(is_atomic_out));
    check_field(names[k], "is_branch_out",
                32'(e_opcode[k] inside {[32'd12:32'd14]}), 32'(is_branch_out));
    if (!e_bubble[k][0]) begin
      check_field(names[k], "pc_out", x_pc[k], pc_out);
    end
    // killed and faulting slots carry no control
    if (e_bubble[k][0] || (e_exc[k] != 32'd0)) begin
      check_field(names[k], "alu_op_out", 32'd0, 32'(alu_op_out));
      check_field(names[k], "tgt_2_out", 32'd0, 32'(tgt_2_out));
      check_field(names[k], "branch_code_out", 32'd0, 32'(branch_code_out));
      check_field(names[k], "is_post_inc_out", 32'd0, 32'(is_post_inc_out));
    end else if (x_atomic[k] && (e_step[k] == 32'd1)) begin
      // middle fetch-add micro-op is an alu add
      check_field(names[k], "alu_op_out", 32'd14, 32'(alu_op_out));
    end
  endtask

  initial begin
    void'($urandom(32'h8e4bb6e3));
    rst_n = 1'b0;
    instr = '0;
    pc = '0;
    instr_valid = 1'b0;
    kmode = 1'b0;
    stall = 1'b0;
    flush = 1'b0;
    loaded = 1'b0;
    read_golden();
    derive_held_outputs();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_field("reset", "bubble_out", 32'd1, 32'(bubble_out));
    check_field("reset", "opcode_out", 32'd0, 32'(opcode_out));
    check_field("reset", "alu_op_out", 32'd0, 32'(alu_op_out));
    check_field("reset", "s_1_out", 32'd0, 32'(s_1_out));
    check_field("reset", "s_2_out", 32'd0, 32'(s_2_out));
    check_field("reset", "tgt_1_out", 32'd0, 32'(tgt_1_out));
    check_field("reset", "tgt_2_out", 32'd0, 32'(tgt_2_out));
    check_field("reset", "imm_out", 32'd0, imm_out);
    check_field("reset", "branch_code_out", 32'd0, 32'(branch_code_out));
    check_field("reset", "exc_out", 32'd0, 32'(exc_out));
    check_field("reset", "pc_out", 32'd0, pc_out);
    check_field("reset", "is_load_out", 32'd0, 32'(is_load_out));
    check_field("reset", "is_store_out", 32'd0, 32'(is_store_out));
    check_field("reset", "is_branch_out", 32'd0, 32'(is_branch_out));
    check_field("reset", "is_post_inc_out", 32'd0, 32'(is_post_inc_out));
    check_field("reset", "is_atomic_out", 32'd0, 32'(is_atomic_out));
    check_field("reset", "atomic_step_out", 32'd0, 32'(atomic_step_out));
    check_field("reset", "decode_stall", 32'd0, 32'(decode_stall));
    for (int k = 0; k < num_vec; k++) begin
      drive_vector(k);
      #(period - 4);
      check_field(names[k], "decode_stall", e_dstall[k], 32'(decode_stall));
      if (k > 0) begin
        check_registered(k - 1);
      end
      @(posedge clk);
      #2;
    end
    drive_idle();
    #(period - 4);
    check_registered(num_vec - 1);
    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog sized from the vector count plus reset and margin
  initial begin
    wait (loaded);
    #(period * (num_vec + 10 + 20));
    stop_with_error("timeout: the run did not finish in the expected time");
  end

endmodule

/* tb/golden_decode.txt */
# name stall flush instr_valid kmode instr pc | expected after next edge:
# bubble opcode s_1 s_2 tgt_1 imm exc is_load is_store atomic_step decode_stall (all hex)
reset_idle 0 0 0 0 00000000 00001000 1 0 0 0 0 00000000 00 0 0 0 0
alu_reg 0 0 1 0 00c80045 00001004 0 0 4 5 3 00000000 00 0 0 0 0
alu_imm_bitwise 0 0 1 0 084431ab 00001008 0 1 2 0 1 0000ab00 00 0 0 0 0
alu_imm_shift 0 0 1 0 098e83f7 0000100c 0 1 7 0 6 00000017 00 0 0 0 0
alu_imm_arith 0 0 1 0 0892e9c4 00001010 0 1 9 0 2 fffff9c4 00 0 0 0 0
lui 0 0 1 0 12012345 00001014 0 2 0 0 8 048d1400 00 0 0 0 0
load_abs_w 0 0 1 0 194d2801 00001018 0 3 6 0 5 ffffe004 00 1 0 0 0
store_rel_h 0 0 1 0 3a968123 0000101c 0 7 b a 0 ffff8123 00 0 1 0 0
load_imm_b 0 0 1 0 5b300010 00001020 0 b 0 0 c fff00010 00 1 0 0 0
store_imm_w 0 0 1 0 28400ff0 00001024 0 5 0 1 0 00000ff0 00 0 1 0 0
rsvd_opcode 0 0 1 0 b8000000 00001028 0 0 0 0 0 00000000 80 0 0 0 0
bad_alu_op 0 0 1 0 08014000 0000102c 0 0 0 0 0 00000000 80 0 0 0 0
bad_syscall 0 0 1 0 78000002 00001030 0 0 0 0 0 00000000 80 0 0 0 0
good_syscall 0 0 1 0 78000001 00001034 0 0 0 0 0 00000000 01 0 0 0 0
priv_user 0 0 1 0 f8801000 00001038 0 0 0 0 0 00000000 81 0 0 0 0
priv_kernel 0 0 1 1 f8801000 0000103c 0 1f 0 2 2 00000000 00 0 0 0 0
idle_a 0 0 0 0 00000000 00001040 1 0 0 0 0 00000000 00 0 0 0 0
fadd_load 0 0 1 0 80c85010 00001044 0 3 5 4 3 00000010 00 1 0 0 1
fadd_add 0 0 1 0 80c85010 00001044 0 0 4 3 3 00000000 00 0 0 1 1
fadd_store 0 0 1 0 80c85010 00001044 0 3 5 3 0 00000010 00 0 1 2 1
idle_b 0 0 0 0 00000000 00001048 1 0 0 0 0 00000000 00 0 0 0 0
swap_load 0 0 1 0 a1d09fff 0000104c 0 4 9 8 7 ffffffff 00 1 0 0 1
swap_store 0 0 1 0 a1d09fff 0000104c 0 4 9 8 0 ffffffff 00 0 1 2 1
idle_c 0 0 0 0 00000000 00001050 1 0 0 0 0 00000000 00 0 0 0 0
stall_base 0 0 1 0 0892e9c4 00001054 0 1 9 0 2 fffff9c4 00 0 0 0 0
stall_hold 1 0 1 0 b8000000 00001058 0 1 9 0 2 fffff9c4 00 0 0 0 0
fadd_imm_load 0 0 1 0 90440020 0000105c 0 5 0 2 1 00000020 00 1 0 0 1
flush_cancel 0 1 1 0 90440020 0000105c 1 0 0 0 0 00000000 00 0 0 0 1
after_flush 0 0 0 0 00000000 00001060 1 0 0 0 0 00000000 00 0 0 0 0
idle_end 0 0 0 0 00000000 00001064 1 0 0 0 0 00000000 00 0 0 0 0

/* sim.f */
rtl/decode_pkg.sv
rtl/instr_classifier.sv
rtl/imm_gen.sv
rtl/reg_select.sv
rtl/atomic_cracker.sv
rtl/decode_stage.sv
tb/tb_decode.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_decode -f sim.f -Mdir obj_dir -o tb_decode
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/tb_decode
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
